/* compile.f */
+incdir+.
kbd_pkg.sv
kbd_matrix.sv
pia_snoop.sv
kbd_read_merge.sv
pet_keyboard.sv
tb_pet_keyboard.sv

/* kbd_config.svh */
// Keyboard block configuration
// Matrix geometry, Wishbone window and PIA register numbers

`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// Key matrix geometry
`define KBD_ROW_COUNT   10              // PET matrix has 10 rows of 8 keys
`define KBD_ADDR_WIDTH  4               // Row index width

// Wishbone address map
`define WB_ADDR_WIDTH   17
`define WB_KBD_BASE     13'h1800        // Upper address bits of the keyboard window

// PIA1 register selects (cpu_addr[1:0])
`define PIA_PORTA       2'd0            // Row select output
`define PIA_PORTB       2'd2            // Column input

`endif

/* kbd_matrix.sv */
// Keyboard matrix store
// Wishbone slave holding the 10x8 active-low key matrix. Decodes the
// keyboard window, acks one cycle after each request and gives the
// CPU side an asynchronous read port on the selected row

`timescale 1ns/1ps
`include "kbd_config.svh"

module kbd_matrix (
    input  logic               wb_clock_i,
    input  logic               reset_i,
    input  kbd_pkg::wb_req_t   wb_req_i,
    output kbd_pkg::kbd_data_t wb_data_o,
    output logic               wb_ack_o,
    input  kbd_pkg::kbd_row_t  cpu_row_i,
    output kbd_pkg::kbd_data_t cpu_row_data_o
);
    import kbd_pkg::*;

    // A pressed key clears its bit, an idle row reads FF
    kbd_data_t matrix [`KBD_ROW_COUNT];

    kbd_row_t wb_row;           // Row index from the low address bits
    logic     wb_select;        // Valid request inside the window
    logic     wb_row_valid;     // Row exists in the matrix
    logic     matrix_we;

    assign wb_row       = wb_req_i.addr[`KBD_ADDR_WIDTH-1:0];
    assign wb_select    = wb_req_i.valid
                       && (wb_req_i.addr[`WB_ADDR_WIDTH-1:`KBD_ADDR_WIDTH] == `WB_KBD_BASE);
    assign wb_row_valid = (wb_row < `KBD_ROW_COUNT);

    // Rows 10..15 are acked but never stored
    assign matrix_we = wb_select && wb_req_i.we && wb_row_valid;

    // Matrix array, all keys released after reset
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            for (int i = 0; i < `KBD_ROW_COUNT; i++) begin
                matrix[i] <= 8'hFF;
            end
        end else if (matrix_we) begin
            matrix[wb_row] <= wb_req_i.data;
        end
    end

    // Ack exactly one clock after each accepted request
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_select;       // No back-pressure, so acks can be back to back
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge wb_clock_i) begin
        if (wb_select && !wb_req_i.we) begin
            wb_data_o <= wb_row_valid ? matrix[wb_row] : 8'hFF;
        end
    end

    // CPU read port, rows past the matrix look like no keys pressed
    assign cpu_row_data_o = (cpu_row_i < `KBD_ROW_COUNT) ? matrix[cpu_row_i] : 8'hFF;

    // Every ack traces back to a valid request on the previous edge
    ack_after_req: assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        $rose(wb_ack_o) |-> $past(wb_req_i.valid)
    ) else $error("kbd_matrix: ack without a request");

    // A write past the last row leaves the row seen by the CPU port alone
    write_in_range: assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        wb_select && wb_req_i.we && !wb_row_valid
            |=> $changed(cpu_row_i) || $stable(cpu_row_data_o)
    ) else $error("kbd_matrix: write past last row");

endmodule

/* kbd_pkg.sv */
// Keyboard block types
// Data, row and register-select types plus the Wishbone request
// and PIA snoop structs shared between the keyboard modules

`include "kbd_config.svh"

package kbd_pkg;

    typedef logic [7:0]                 kbd_data_t;     // One matrix row, active low
    typedef logic [`KBD_ADDR_WIDTH-1:0] kbd_row_t;      // Row index
    typedef logic [1:0]                 pia_rs_t;       // PIA register select

    // One Wishbone request, valid is cycle AND strobe
    typedef struct packed {
        logic [`WB_ADDR_WIDTH-1:0] addr;
        kbd_data_t                 data;
        logic                      we;
        logic                      valid;
    } wb_req_t;

    // CPU side view of the PIA
    typedef struct packed {
        kbd_row_t row;              // Row last written to port A
        logic     port_b_read;      // Port B read in progress
    } snoop_t;

endpackage

/* kbd_read_merge.sv */
// Keyboard read merge
// Registers the selected row and decides when the keyboard block
// takes over the CPU data bus during a port B read

`timescale 1ns/1ps

module kbd_read_merge (
    input  logic               wb_clock_i,
    input  logic               reset_i,
    input  kbd_pkg::snoop_t    snoop_i,
    input  kbd_pkg::kbd_data_t row_data_i,     // Selected row from the matrix
    output kbd_pkg::kbd_data_t cpu_data_o,
    output logic               cpu_data_oe_o   // Drive the CPU data bus
);
    import kbd_pkg::*;

    localparam kbd_data_t NO_KEYS = 8'hFF;     // Row with nothing pressed

    // Follows matrix writes and row changes one clock later
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            cpu_data_o <= NO_KEYS;
        end else begin
            cpu_data_o <= row_data_i;
        end
    end

    // Only intercept the read when some key in the row is down,
    // otherwise the real PIA answers
    assign cpu_data_oe_o = snoop_i.port_b_read && (cpu_data_o != NO_KEYS);

    // An idle row is never driven onto the CPU bus
    no_idle_drive: assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        cpu_data_oe_o |-> $past(row_data_i) != NO_KEYS
    ) else $error("kbd_read_merge: driving an idle row");

endmodule

/* pet_keyboard.sv */
// PET keyboard block
// Presents a host-written key matrix to the CPU as PIA1 would.
// Packs the Wishbone and CPU inputs and joins the matrix store,
// the PIA snoop and the read merge

`timescale 1ns/1ps
`include "kbd_config.svh"

module pet_keyboard (
    input  logic                      wb_clock_i,
    input  logic                      reset_i,
    input  logic [`WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  kbd_pkg::kbd_data_t        wb_data_i,
    output kbd_pkg::kbd_data_t        wb_data_o,
    input  logic                      wb_we_i,
    input  logic                      wb_cycle_i,
    input  logic                      wb_strobe_i,
    output logic                      wb_ack_o,
    input  kbd_pkg::pia_rs_t          pia1_rs_i,
    input  logic                      pia1_cs_i,
    input  logic                      cpu_valid_strobe_i,
    input  logic                      cpu_done_strobe_i,
    input  kbd_pkg::kbd_data_t        cpu_data_i,
    output kbd_pkg::kbd_data_t        cpu_data_o,
    output logic                      cpu_data_oe_o,
    input  logic                      cpu_we_i
);
    import kbd_pkg::*;

    wb_req_t   wb_req;
    snoop_t    snoop;
    kbd_data_t row_data;        // Selected row, straight from the matrix

    // Wishbone request
    assign wb_req.addr  = wb_addr_i;
    assign wb_req.data  = wb_data_i;
    assign wb_req.we    = wb_we_i;
    assign wb_req.valid = wb_cycle_i && wb_strobe_i;

    kbd_matrix matrix0 (
        .wb_clock_i    (wb_clock_i),
        .reset_i       (reset_i),
        .wb_req_i      (wb_req),
        .wb_data_o     (wb_data_o),
        .wb_ack_o      (wb_ack_o),
        .cpu_row_i     (snoop.row),
        .cpu_row_data_o(row_data)
    );

    pia_snoop snoop0 (
        .wb_clock_i        (wb_clock_i),
        .reset_i           (reset_i),
        .pia1_rs_i         (pia1_rs_i),
        .pia1_cs_i         (pia1_cs_i),
        .cpu_valid_strobe_i(cpu_valid_strobe_i),
        .cpu_done_strobe_i (cpu_done_strobe_i),
        .cpu_we_i          (cpu_we_i),
        .cpu_data_i        (cpu_data_i),
        .snoop_o           (snoop)
    );

    kbd_read_merge merge0 (
        .wb_clock_i   (wb_clock_i),
        .reset_i      (reset_i),
        .snoop_i      (snoop),
        .row_data_i   (row_data),
        .cpu_data_o   (cpu_data_o),
        .cpu_data_oe_o(cpu_data_oe_o)
    );

endmodule

/* pia_snoop.sv */
// PIA1 snoop
// Watches CPU accesses to PIA1. Port A writes select the keyboard row,
// port B reads raise a flag that holds until the CPU cycle completes

`timescale 1ns/1ps
`include "kbd_config.svh"

module pia_snoop (
    input  logic               wb_clock_i,
    input  logic               reset_i,
    input  kbd_pkg::pia_rs_t   pia1_rs_i,          // PIA register select
    input  logic               pia1_cs_i,          // PIA chip select
    input  logic               cpu_valid_strobe_i, // CPU address and data valid
    input  logic               cpu_done_strobe_i,  // CPU cycle complete
    input  logic               cpu_we_i,
    input  kbd_pkg::kbd_data_t cpu_data_i,
    output kbd_pkg::snoop_t    snoop_o
);
    import kbd_pkg::*;

    logic     pia_access;
    logic     port_a_write;     // CPU selecting the next row
    logic     port_b_start;     // CPU starting a column read
    kbd_row_t row_q;
    logic     port_b_read_q;

    assign pia_access   = cpu_valid_strobe_i && pia1_cs_i;
    assign port_a_write = pia_access &&  cpu_we_i && (pia1_rs_i == `PIA_PORTA);
    assign port_b_start = pia_access && !cpu_we_i && (pia1_rs_i == `PIA_PORTB);

    // Row select, rows 10 and up are kept as written
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            row_q <= '0;
        end else if (port_a_write) begin
            row_q <= cpu_data_i[`KBD_ADDR_WIDTH-1:0];   // Low bits only
        end
    end

    // Port B read flag, set on the valid strobe and cleared on done
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            port_b_read_q <= 1'b0;
        end else if (port_b_start) begin
            port_b_read_q <= 1'b1;
        end else if (cpu_done_strobe_i) begin
            port_b_read_q <= 1'b0;
        end
    end

    assign snoop_o.row         = row_q;
    assign snoop_o.port_b_read = port_b_read_q;

    // Bus timing generator never overlaps the two strobes
    strobes_apart: assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        !(cpu_valid_strobe_i && cpu_done_strobe_i)
    ) else $error("pia_snoop: valid and done strobes together");

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the PET keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_pet_keyboard -f compile.f -o tb_pet_keyboard
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_pet_keyboard)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tb_pet_keyboard.sv */
// Testbench for the PET keyboard block
// Drives the Wishbone port and the PIA1 snoop inputs. A shadow matrix
// and a cycle model of the snoop predict every DUT output, and a
// compare process checks them on each falling edge

`timescale 1ns/1ps
`include "kbd_config.svh"

module tb_pet_keyboard;
    import kbd_pkg::*;

    localparam int TEST_CYCLES = 64 + 160 + 120 + 30 + 1800;   // Budgets of tests 1 to 5
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 100;

    logic                      wb_clock_i;
    logic                      reset_i;
    logic [`WB_ADDR_WIDTH-1:0] wb_addr_i;
    kbd_data_t                 wb_data_i;
    kbd_data_t                 wb_data_o;
    logic                      wb_we_i;
    logic                      wb_cycle_i;
    logic                      wb_strobe_i;
    logic                      wb_ack_o;
    pia_rs_t                   pia1_rs_i;
    logic                      pia1_cs_i;
    logic                      cpu_valid_strobe_i;
    logic                      cpu_done_strobe_i;
    kbd_data_t                 cpu_data_i;
    kbd_data_t                 cpu_data_o;
    logic                      cpu_data_oe_o;
    logic                      cpu_we_i;

    // Reference model state
    kbd_data_t shadow [`KBD_ROW_COUNT];    // Expected matrix contents
    kbd_row_t  model_row;
    logic      model_port_b;               // Port B read in progress
    kbd_data_t model_cpu_data;
    logic      model_ack;
    logic      model_ack_read;
    kbd_data_t model_rdata;

    int          error_count;
    int          test_start_errors;
    int          tests_run;
    int          tests_passed;
    int          cycle_count;
    int          seed;
    int          latency;
    logic        got_ack;
    logic [31:0] rnd;
    kbd_data_t   rdata;

    pet_keyboard dut0 (.*);

    initial begin
        wb_clock_i = 1'b0;
        forever #5 wb_clock_i = ~wb_clock_i;
    end

    // Run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge wb_clock_i);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    // Rows past the matrix read as no keys pressed
    function automatic kbd_data_t expected_row(input kbd_row_t row);
        return (row < `KBD_ROW_COUNT) ? shadow[row] : 8'hFF;
    endfunction

    function automatic logic expected_oe(input logic port_b, input kbd_data_t data);
        return port_b && (data != 8'hFF);      // Drive only with a key down
    endfunction

    function automatic logic [`WB_ADDR_WIDTH-1:0] window_addr(input kbd_row_t row);
        return {`WB_KBD_BASE, row};
    endfunction

    task automatic report_mismatch(input string name, input logic [7:0] actual,
                                   input logic [7:0] expected);
        error_count++;
        $display("Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
    endtask

    task automatic note_failure(input string text);
        error_count++;
        $display("At %0t: %s", $time, text);
    endtask

    // Model follows the DUT inputs as sampled on each rising edge
    always @(posedge wb_clock_i) begin : reference_model
        logic     wb_hit;
        kbd_row_t wb_row;
        wb_row = wb_addr_i[`KBD_ADDR_WIDTH-1:0];
        wb_hit = wb_cycle_i && wb_strobe_i
              && (wb_addr_i[`WB_ADDR_WIDTH-1:`KBD_ADDR_WIDTH] == `WB_KBD_BASE);
        if (reset_i) begin
            for (int i = 0; i < `KBD_ROW_COUNT; i++) begin
                shadow[i] = 8'hFF;
            end
            model_row      = '0;
            model_port_b   = 1'b0;
            model_cpu_data = 8'hFF;
            model_ack      = 1'b0;
            model_ack_read = 1'b0;
        end else begin
            model_cpu_data = expected_row(model_row);     // Old row, old contents
            model_ack      = wb_hit;
            model_ack_read = wb_hit && !wb_we_i;
            if (wb_hit && !wb_we_i) model_rdata = expected_row(wb_row);
            if (wb_hit && wb_we_i && wb_row < `KBD_ROW_COUNT) shadow[wb_row] = wb_data_i;
            if (cpu_valid_strobe_i && pia1_cs_i && cpu_we_i && pia1_rs_i == `PIA_PORTA)
                model_row = cpu_data_i[`KBD_ADDR_WIDTH-1:0];
            if (cpu_valid_strobe_i && pia1_cs_i && !cpu_we_i && pia1_rs_i == `PIA_PORTB)
                model_port_b = 1'b1;
            else if (cpu_done_strobe_i)
                model_port_b = 1'b0;
        end
    end

    // Compare process, outputs are settled mid-cycle
    always @(negedge wb_clock_i) begin
        if (!reset_i) begin
            if (wb_ack_o !== model_ack)
                report_mismatch("wb_ack_o", {7'b0, wb_ack_o}, {7'b0, model_ack});
            if (model_ack_read && wb_data_o !== model_rdata)
                report_mismatch("wb_data_o", wb_data_o, model_rdata);
            if (cpu_data_o !== model_cpu_data)
                report_mismatch("cpu_data_o", cpu_data_o, model_cpu_data);
            if (cpu_data_oe_o !== expected_oe(model_port_b, model_cpu_data))
                report_mismatch("cpu_data_oe_o", {7'b0, cpu_data_oe_o},
                                {7'b0, expected_oe(model_port_b, model_cpu_data)});
        end
    end

    // One Wishbone request, then wait up to 3 cycles for the ack
    task automatic wb_transfer(input logic [`WB_ADDR_WIDTH-1:0] addr, input logic we,
                               input kbd_data_t wdata, output logic acked,
                               output int wait_cycles, output kbd_data_t data);
        @(posedge wb_clock_i);
        wb_addr_i   <= addr;
        wb_data_i   <= wdata;
        wb_we_i     <= we;
        wb_cycle_i  <= 1'b1;
        wb_strobe_i <= 1'b1;
        @(posedge wb_clock_i);                  // Request taken here
        wb_cycle_i  <= 1'b0;
        wb_strobe_i <= 1'b0;
        wb_we_i     <= 1'b0;
        wait_cycles = 1;
        @(negedge wb_clock_i);
        while (!wb_ack_o && wait_cycles < 3) begin
            @(negedge wb_clock_i);
            wait_cycles++;
        end
        acked = wb_ack_o;
        data  = wb_data_o;
        if (acked) begin
            @(negedge wb_clock_i);
            if (wb_ack_o) note_failure("wb_ack_o held high for more than one cycle");
        end
    endtask

    task automatic wb_row_access(input kbd_row_t row, input logic we, input kbd_data_t wdata);
        logic      acked;
        int        wait_cycles;
        kbd_data_t data;
        wb_transfer(window_addr(row), we, wdata, acked, wait_cycles, data);
        if (!acked || wait_cycles != 1)
            note_failure($sformatf("Row %0d access not acked one cycle after request", row));
        else if (!we && data !== expected_row(row))
            report_mismatch("wb_data_o", data, expected_row(row));
    endtask

    // One CPU cycle to PIA1 with a single valid strobe
    task automatic pia_access(input logic cs, input pia_rs_t rs, input logic we,
                              input kbd_data_t data);
        @(posedge wb_clock_i);
        pia1_cs_i          <= cs;
        pia1_rs_i          <= rs;
        cpu_we_i           <= we;
        cpu_data_i         <= data;
        cpu_valid_strobe_i <= 1'b1;
        @(posedge wb_clock_i);
        cpu_valid_strobe_i <= 1'b0;
        pia1_cs_i          <= 1'b0;
    endtask

    task automatic cpu_done();
        @(posedge wb_clock_i);
        cpu_done_strobe_i <= 1'b1;
        @(posedge wb_clock_i);
        cpu_done_strobe_i <= 1'b0;
    endtask

    // Select a row through port A, read it through port B, end the cycle
    task automatic scan_row(input kbd_data_t select);
        kbd_data_t expect_data;
        pia_access(1'b1, `PIA_PORTA, 1'b1, select);
        pia_access(1'b1, `PIA_PORTB, 1'b0, 8'h00);
        @(negedge wb_clock_i);
        expect_data = expected_row(select[`KBD_ADDR_WIDTH-1:0]);
        if (cpu_data_o !== expect_data) report_mismatch("cpu_data_o", cpu_data_o, expect_data);
        if (cpu_data_oe_o !== expected_oe(1'b1, expect_data))
            report_mismatch("cpu_data_oe_o", {7'b0, cpu_data_oe_o},
                            {7'b0, expected_oe(1'b1, expect_data)});
        cpu_done();
        @(negedge wb_clock_i);
        if (cpu_data_oe_o !== 1'b0) note_failure("cpu_data_oe_o still high after done strobe");
    endtask

    // Rejected access, row and bus driver must stay put
    task automatic check_no_drive(input kbd_data_t held);
        repeat (2) @(negedge wb_clock_i);        // Row change would show by now
        if (cpu_data_oe_o !== 1'b0) note_failure("cpu_data_oe_o driven by a rejected access");
        if (cpu_data_o !== held) report_mismatch("cpu_data_o", cpu_data_o, held);
    endtask

    task automatic finish_test(input string name);
        int errors;
        errors = error_count - test_start_errors;
        tests_run++;
        if (errors == 0) begin
            tests_passed++;
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_run, name, errors);
        end
        test_start_errors = error_count;
    endtask

    initial begin
        seed               = 32'h40a3;
        error_count        = 0;
        test_start_errors  = 0;
        tests_run          = 0;
        tests_passed       = 0;
        reset_i            = 1'b1;
        wb_addr_i          = '0;
        wb_data_i          = '0;
        wb_we_i            = 1'b0;
        wb_cycle_i         = 1'b0;
        wb_strobe_i        = 1'b0;
        pia1_rs_i          = '0;
        pia1_cs_i          = 1'b0;
        cpu_valid_strobe_i = 1'b0;
        cpu_done_strobe_i  = 1'b0;
        cpu_data_i         = '0;
        cpu_we_i           = 1'b0;
        repeat (5) @(posedge wb_clock_i);
        reset_i <= 1'b0;

        for (int r = 0; r < 16; r++) wb_row_access(r[3:0], 1'b0, 8'h00);
        if (cpu_data_oe_o !== 1'b0) note_failure("cpu_data_oe_o high after reset");
        finish_test("reset state");

        for (int r = 0; r < 16; r++) wb_row_access(r[3:0], 1'b1, 8'h5A ^ r[7:0]);
        for (int r = 0; r < 16; r++) wb_row_access(r[3:0], 1'b0, 8'h00);
        wb_transfer({`WB_KBD_BASE + 13'd1, 4'h2}, 1'b1, 8'h00, got_ack, latency, rdata);
        if (got_ack) note_failure("Write outside the keyboard window was acked");
        wb_transfer('0, 1'b0, 8'h00, got_ack, latency, rdata);
        if (got_ack) note_failure("Read outside the keyboard window was acked");
        wb_row_access(4'd2, 1'b0, 8'h00);       // Stray write left row 2 alone
        finish_test("wishbone access");

        for (int r = 0; r < `KBD_ROW_COUNT; r++)
            wb_row_access(r[3:0], 1'b1, (r % 3 == 0) ? 8'hFF : ~(8'h01 << (r % 8)));
        for (int r = 0; r < `KBD_ROW_COUNT; r++) scan_row({4'h0, r[3:0]});
        finish_test("row scan");

        scan_row(8'h01);                        // Row 1 has a key down
        pia_access(1'b0, `PIA_PORTA, 1'b1, 8'h05);
        check_no_drive(expected_row(4'd1));
        pia_access(1'b1, 2'd1, 1'b1, 8'h05);    // Control register write
        check_no_drive(expected_row(4'd1));
        pia_access(1'b1, `PIA_PORTB, 1'b1, 8'h05);
        check_no_drive(expected_row(4'd1));
        pia_access(1'b0, `PIA_PORTB, 1'b0, 8'h00);
        check_no_drive(expected_row(4'd1));
        pia_access(1'b1, 2'd3, 1'b0, 8'h00);
        check_no_drive(expected_row(4'd1));
        finish_test("no false drive");

        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            case (rnd[9:8])
                2'd0, 2'd1: wb_row_access(rnd[3:0], 1'b1, rnd[10] ? 8'hFF : rnd[23:16]);
                2'd2:       wb_row_access(rnd[3:0], 1'b0, 8'h00);
                default:    scan_row(rnd[7:0]);   // Upper bits of the select are ignored
            endcase
        end
        finish_test("random mix");

        $display("Tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
